/* rtl/host_chan_events_pkg.sv */
// Host channel event package
// TLP field types, format/type codes and the event record that the read
// tracker hands to the accumulator, plus the header decode helpers

`default_nettype none

package host_chan_events_pkg;

    // Raw TLP header fields, as seen on each channel
    typedef logic [7:0] t_fmttype;
    typedef logic [9:0] t_tlp_length;

    // One cycle's DWORD sum, or several cycles' sums merged while out of credit
    typedef logic [15:0] t_dword_count;

    // Pair of sums moved through the credit FIFO in one entry
    typedef struct packed {
        t_dword_count req_dwords;
        t_dword_count rsp_dwords;
    } t_read_event;

    // Running totals kept by the accumulator
    typedef logic [47:0] t_event_total;

    // Memory read requests, 3DW and 4DW header forms
    localparam t_fmttype FMTTYPE_MRD32 = 8'h00;
    localparam t_fmttype FMTTYPE_MRD64 = 8'h20;

    // Completions, with and without a data payload
    localparam t_fmttype FMTTYPE_CPLD = 8'h4A;
    localparam t_fmttype FMTTYPE_CPL  = 8'h0A;

    // True for either header form of a memory read request
    function automatic logic is_mrd_req(input t_fmttype fmttype);
        return (fmttype == FMTTYPE_MRD32) || (fmttype == FMTTYPE_MRD64);
    endfunction

    // True only for a completion that carries data
    // A completion without data returns nothing to the requester
    function automatic logic is_cpl_with_data(input t_fmttype fmttype);
        return fmttype == FMTTYPE_CPLD;
    endfunction

    // Number of DWORDs described by a length field
    // The field is 10 bits wide, so the value 0 encodes the maximum of 1024
    function automatic t_dword_count tlp_dwords(input t_tlp_length length);
        t_dword_count n;

        if (length == '0)
        begin
            n = t_dword_count'(1024);
        end
        else
        begin
            n = t_dword_count'(length);
        end
        return n;
    endfunction

endpackage

`default_nettype wire

/* rtl/tlp_read_tracker.sv */
// TLP read tracker
// Sums the DWORD length of read requests on the transmit side and of
// completions with data on the receive side, one pair of sums per cycle.
// Sums go to the credit FIFO and are merged locally while no credit is left

`timescale 1ns/1ps
`default_nettype none

module tlp_read_tracker
    import host_chan_events_pkg::*;
#(
    parameter int NUM_CH    = 2,
    parameter int BUF_DEPTH = 4
)
(
    input  wire logic                      clk,
    input  wire logic                      reset,

    input  wire logic                      en_tx,
    input  wire logic [NUM_CH-1:0]         tx_valid,
    input  wire logic [NUM_CH-1:0]         tx_sop,
    input  wire logic [NUM_CH-1:0]         tx_irq,
    input  wire t_fmttype [NUM_CH-1:0]     tx_fmttype,
    input  wire t_tlp_length [NUM_CH-1:0]  tx_length,

    input  wire logic                      en_rx,
    input  wire logic [NUM_CH-1:0]         rx_valid,
    input  wire logic [NUM_CH-1:0]         rx_sop,
    input  wire t_fmttype [NUM_CH-1:0]     rx_fmttype,
    input  wire t_tlp_length [NUM_CH-1:0]  rx_length,

    input  wire logic                      credit_return,
    output logic                           push,
    output t_read_event                    push_data
);

    localparam int CREDIT_W = $clog2(BUF_DEPTH + 1);

    // First stage holds the decoded DWORD count of every qualifying beat
    t_dword_count req_ch_q [NUM_CH];
    t_dword_count rsp_ch_q [NUM_CH];

    // Second stage holds the sum over all channels
    t_dword_count sum_req_q;
    t_dword_count sum_rsp_q;

    // Sums that arrived while the FIFO had no room
    t_dword_count held_req;
    t_dword_count held_rsp;

    // One extra bit so that an overflow of the merge can be seen
    logic [16:0] merged_req;
    logic [16:0] merged_rsp;

    logic [CREDIT_W-1:0] credit;
    logic                has_credit;

    // Decode each channel separately so the adder tree sees registered inputs
    always_ff @(posedge clk)
    begin
        for (int c = 0; c < NUM_CH; c = c + 1)
        begin
            if (reset)
            begin
                req_ch_q[c] <= '0;
                rsp_ch_q[c] <= '0;
            end
            else
            begin
                // Interrupt beats share the request path but return no data
                if (en_tx && tx_valid[c] && tx_sop[c] && !tx_irq[c] &&
                    is_mrd_req(tx_fmttype[c]))
                    req_ch_q[c] <= tlp_dwords(tx_length[c]);
                else
                    req_ch_q[c] <= '0;

                if (en_rx && rx_valid[c] && rx_sop[c] && is_cpl_with_data(rx_fmttype[c]))
                    rsp_ch_q[c] <= tlp_dwords(rx_length[c]);
                else
                    rsp_ch_q[c] <= '0;
            end
        end
    end

    always_ff @(posedge clk)
    begin
        t_dword_count acc_req;
        t_dword_count acc_rsp;

        acc_req = '0;
        acc_rsp = '0;
        for (int c = 0; c < NUM_CH; c = c + 1)
        begin
            acc_req = acc_req + req_ch_q[c];
            acc_rsp = acc_rsp + rsp_ch_q[c];
        end

        if (reset)
        begin
            sum_req_q <= '0;
            sum_rsp_q <= '0;
        end
        else
        begin
            sum_req_q <= acc_req;
            sum_rsp_q <= acc_rsp;
        end
    end

    // New sums always merge with whatever is being held back
    assign merged_req = {1'b0, sum_req_q} + {1'b0, held_req};
    assign merged_rsp = {1'b0, sum_rsp_q} + {1'b0, held_rsp};

    assign has_credit = (credit != '0);

    // Empty records are never pushed since they would only cost a credit
    assign push = has_credit && ((merged_req != '0) || (merged_rsp != '0));
    assign push_data.req_dwords = merged_req[15:0];
    assign push_data.rsp_dwords = merged_rsp[15:0];

    // With credit the merge is either pushed or zero, so the hold empties
    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            held_req <= '0;
            held_rsp <= '0;
        end
        else if (has_credit)
        begin
            held_req <= '0;
            held_rsp <= '0;
        end
        else
        begin
            held_req <= merged_req[15:0];
            held_rsp <= merged_rsp[15:0];
        end
    end

    // One credit per free FIFO slot that the FIFO returns after each pop
    always_ff @(posedge clk)
    begin
        if (reset)
            credit <= CREDIT_W'(BUF_DEPTH);
        else if (push && !credit_return)
            credit <= credit - 1'b1;
        else if (!push && credit_return)
            credit <= credit + 1'b1;
    end

    // A spurious credit_return from the FIFO would push the count past depth
    assert property (@(posedge clk) disable iff (reset)
        credit <= CREDIT_W'(BUF_DEPTH));

    // Held sums must stay within the 16-bit record fields
    assert property (@(posedge clk) disable iff (reset)
        !merged_req[16] && !merged_rsp[16]);

endmodule

`default_nettype wire

/* rtl/event_credit_fifo.sv */
// Credit FIFO for event records
// Circular buffer between the read tracker and the accumulator. Each pop
// hands one credit back to the producer on the following cycle

`timescale 1ns/1ps
`default_nettype none

module event_credit_fifo
    import host_chan_events_pkg::*;
#(
    parameter int  BUF_DEPTH = 4,
    parameter type payload_t = t_read_event
)
(
    input  wire logic     clk,
    input  wire logic     reset,

    input  wire logic     push,
    input  wire payload_t push_data,

    input  wire logic     pop,
    output logic          head_valid,
    output payload_t      head_data,

    output logic          credit_return
);

    localparam int PTR_W   = (BUF_DEPTH > 1) ? $clog2(BUF_DEPTH) : 1;
    localparam int COUNT_W = $clog2(BUF_DEPTH + 1);

    payload_t mem [BUF_DEPTH];

    logic [PTR_W-1:0]   wr_ptr;
    logic [PTR_W-1:0]   rd_ptr;
    logic [COUNT_W-1:0] count;

    // Pointer advance with explicit wrap, so any depth works
    function automatic logic [PTR_W-1:0] next_ptr(input logic [PTR_W-1:0] ptr);
        logic [PTR_W-1:0] n;

        if (ptr == PTR_W'(BUF_DEPTH - 1))
            n = '0;
        else
            n = ptr + 1'b1;
        return n;
    endfunction

    // Storage has no reset, only the pointers decide what is valid
    always_ff @(posedge clk)
    begin
        if (push)
            mem[wr_ptr] <= push_data;
    end

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end
        else
        begin
            if (push)
                wr_ptr <= next_ptr(wr_ptr);
            if (pop)
                rd_ptr <= next_ptr(rd_ptr);

            // Simultaneous push and pop leave the occupancy unchanged
            if (push && !pop)
                count <= count + 1'b1;
            else if (!push && pop)
                count <= count - 1'b1;
        end
    end

    // A slot freed by a pop is offered back one cycle later
    always_ff @(posedge clk)
    begin
        if (reset)
            credit_return <= 1'b0;
        else
            credit_return <= pop;
    end

    // A new entry becomes visible the cycle after its push
    assign head_valid = (count != '0);
    assign head_data  = mem[rd_ptr];

    // The producer's credit count must keep it from ever filling past depth
    assert property (@(posedge clk) disable iff (reset)
        push |-> count != COUNT_W'(BUF_DEPTH));

    // The consumer may only take an entry it can see
    assert property (@(posedge clk) disable iff (reset)
        pop |-> count != '0);

endmodule

`default_nettype wire

/* rtl/event_accumulator.sv */
// Read event accumulator
// Drains event records from the credit FIFO and keeps running totals of
// requested and returned DWORDs and of the DWORDs still outstanding

`timescale 1ns/1ps
`default_nettype none

module event_accumulator
    import host_chan_events_pkg::*;
(
    input  wire logic         clk,
    input  wire logic         reset,

    // Freeze request from whoever reads the totals
    input  wire logic         hold,

    input  wire logic         head_valid,
    input  wire t_read_event  head_data,
    output logic              pop,

    output t_event_total      total_req_dwords,
    output t_event_total      total_rsp_dwords,
    output logic signed [48:0] outstanding_dwords
);

    // Record fields widened to the width of the outstanding counter
    logic signed [48:0] req_ext;
    logic signed [48:0] rsp_ext;

    // Totals stay frozen while held and entries wait in the FIFO meanwhile
    assign pop = head_valid && !hold;

    assign req_ext = $signed({33'b0, head_data.req_dwords});
    assign rsp_ext = $signed({33'b0, head_data.rsp_dwords});

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            total_req_dwords   <= '0;
            total_rsp_dwords   <= '0;
            outstanding_dwords <= '0;
        end
        else if (pop)
        begin
            total_req_dwords <= total_req_dwords + t_event_total'(head_data.req_dwords);
            total_rsp_dwords <= total_rsp_dwords + t_event_total'(head_data.rsp_dwords);

            // Kept apart from the totals so that a wrapped total cannot skew it
            // The extra bit carries the sign when more returned than requested
            outstanding_dwords <= outstanding_dwords + req_ext - rsp_ext;
        end
    end

endmodule

`default_nettype wire

/* rtl/host_chan_events_top.sv */
// Host channel read event monitor
// Taps the transmit and receive TLP streams, counts read request and
// completion DWORDs and presents running totals. Never stalls the traffic

`timescale 1ns/1ps
`default_nettype none

module host_chan_events_top
    import host_chan_events_pkg::*;
#(
    parameter int NUM_CH    = 2,
    parameter int BUF_DEPTH = 4
)
(
    input  wire logic                      clk,
    input  wire logic                      reset,

    input  wire logic                      en_tx,
    input  wire logic [NUM_CH-1:0]         tx_valid,
    input  wire logic [NUM_CH-1:0]         tx_sop,
    input  wire logic [NUM_CH-1:0]         tx_irq,
    input  wire t_fmttype [NUM_CH-1:0]     tx_fmttype,
    input  wire t_tlp_length [NUM_CH-1:0]  tx_length,

    input  wire logic                      en_rx,
    input  wire logic [NUM_CH-1:0]         rx_valid,
    input  wire logic [NUM_CH-1:0]         rx_sop,
    input  wire t_fmttype [NUM_CH-1:0]     rx_fmttype,
    input  wire t_tlp_length [NUM_CH-1:0]  rx_length,

    input  wire logic                      hold,

    output t_event_total                   total_req_dwords,
    output t_event_total                   total_rsp_dwords,
    output logic signed [48:0]             outstanding_dwords
);

    // Tracker to FIFO, credit handshake
    logic        push;
    t_read_event push_data;
    logic        credit_return;

    // FIFO to accumulator
    logic        head_valid;
    t_read_event head_data;
    logic        pop;

    tlp_read_tracker #(
        .NUM_CH    (NUM_CH),
        .BUF_DEPTH (BUF_DEPTH)
    ) tracker (
        .clk           (clk),
        .reset         (reset),
        .en_tx         (en_tx),
        .tx_valid      (tx_valid),
        .tx_sop        (tx_sop),
        .tx_irq        (tx_irq),
        .tx_fmttype    (tx_fmttype),
        .tx_length     (tx_length),
        .en_rx         (en_rx),
        .rx_valid      (rx_valid),
        .rx_sop        (rx_sop),
        .rx_fmttype    (rx_fmttype),
        .rx_length     (rx_length),
        .credit_return (credit_return),
        .push          (push),
        .push_data     (push_data)
    );

    // Depth here must match the credits the tracker starts with
    event_credit_fifo #(
        .BUF_DEPTH (BUF_DEPTH),
        .payload_t (t_read_event)
    ) buffer (
        .clk           (clk),
        .reset         (reset),
        .push          (push),
        .push_data     (push_data),
        .pop           (pop),
        .head_valid    (head_valid),
        .head_data     (head_data),
        .credit_return (credit_return)
    );

    event_accumulator accumulator (
        .clk                (clk),
        .reset              (reset),
        .hold               (hold),
        .head_valid         (head_valid),
        .head_data          (head_data),
        .pop                (pop),
        .total_req_dwords   (total_req_dwords),
        .total_rsp_dwords   (total_rsp_dwords),
        .outstanding_dwords (outstanding_dwords)
    );

endmodule

`default_nettype wire

/* verif/event_checker.sv */
// Read event checker
// Watches the monitor's TLP inputs, keeps its own totals of counted read
// request and completion DWORDs and compares the DUT totals at each test end

`timescale 1ns/1ps
`default_nettype none

module event_checker
    import host_chan_events_pkg::*;
#(
    parameter int NUM_CH = 2
)
(
    input  wire logic                      clk,
    input  wire logic                      reset,

    input  wire logic                      en_tx,
    input  wire logic [NUM_CH-1:0]         tx_valid,
    input  wire logic [NUM_CH-1:0]         tx_sop,
    input  wire logic [NUM_CH-1:0]         tx_irq,
    input  wire t_fmttype [NUM_CH-1:0]     tx_fmttype,
    input  wire t_tlp_length [NUM_CH-1:0]  tx_length,
    input  wire logic                      en_rx,
    input  wire logic [NUM_CH-1:0]         rx_valid,
    input  wire logic [NUM_CH-1:0]         rx_sop,
    input  wire t_fmttype [NUM_CH-1:0]     rx_fmttype,
    input  wire t_tlp_length [NUM_CH-1:0]  rx_length,

    input  wire t_event_total              total_req_dwords,
    input  wire t_event_total              total_rsp_dwords,
    input  wire logic signed [48:0]        outstanding_dwords,

    // Test end strobe with the test's name and the totals the stim file expects
    input  wire logic                      check_now,
    input  wire logic [8*24-1:0]           test_name,
    input  wire t_event_total              file_req,
    input  wire t_event_total              file_rsp,

    output int                             pass_count,
    output int                             fail_count
);

    t_event_total model_req;
    t_event_total model_rsp;

    // MRd with a 3DW or a 4DW header
    function automatic logic counts_as_request(input logic [7:0] fmttype);
        return (fmttype == 8'h00) || (fmttype == 8'h20);
    endfunction

    // Only CplD returns data, a plain Cpl does not
    function automatic logic counts_as_completion(input logic [7:0] fmttype);
        return fmttype == 8'h4A;
    endfunction

    // A zero length field stands for the 1024 DWORD maximum
    function automatic t_event_total length_in_dwords(input logic [9:0] length);
        return (length == 10'd0) ? 48'd1024 : {38'd0, length};
    endfunction

    initial
    begin
        pass_count = 0;
        fail_count = 0;
    end

    // Beats are taken on the same edge at which the DUT samples them
    always @(posedge clk)
    begin
        if (reset)
        begin
            model_req = '0;
            model_rsp = '0;
        end
        else
        begin
            for (int c = 0; c < NUM_CH; c = c + 1)
            begin
                if (en_tx && tx_valid[c] && tx_sop[c] && !tx_irq[c] &&
                    counts_as_request(tx_fmttype[c]))
                    model_req = model_req + length_in_dwords(tx_length[c]);
                if (en_rx && rx_valid[c] && rx_sop[c] && counts_as_completion(rx_fmttype[c]))
                    model_rsp = model_rsp + length_in_dwords(rx_length[c]);
            end
        end
    end

    // Outputs are compared half a cycle away from the edge that updates them
    always @(negedge clk)
    begin
        logic signed [48:0] exp_out;
        logic               ok;

        if (check_now)
        begin
            exp_out = $signed({1'b0, model_req}) - $signed({1'b0, model_rsp});
            ok = 1'b1;
            if ((model_req != file_req) || (model_rsp != file_rsp))
            begin
                $display("Stim file for %0s expects req %0h rsp %0h but its beats add up to req %0h rsp %0h",
                         test_name, file_req, file_rsp, model_req, model_rsp);
                ok = 1'b0;
            end
            if (total_req_dwords !== model_req)
            begin
                $display("Fail %0s total_req_dwords expected %0h actual %0h",
                         test_name, model_req, total_req_dwords);
                ok = 1'b0;
            end
            if (total_rsp_dwords !== model_rsp)
            begin
                $display("Fail %0s total_rsp_dwords expected %0h actual %0h",
                         test_name, model_rsp, total_rsp_dwords);
                ok = 1'b0;
            end
            if (outstanding_dwords !== exp_out)
            begin
                $display("Fail %0s outstanding_dwords expected %0d actual %0d",
                         test_name, exp_out, outstanding_dwords);
                ok = 1'b0;
            end
            if (ok)
            begin
                pass_count = pass_count + 1;
                $display("ok   %0s req=%0h rsp=%0h outstanding=%0d",
                         test_name, model_req, model_rsp, exp_out);
            end
            else
                fail_count = fail_count + 1;
        end
    end

endmodule

`default_nettype wire

/* verif/tb_host_chan_events.sv */
// Testbench for the host channel read event monitor
// Replays beats from the stim file, marks test ends for the checker and
// stops the run with a watchdog sized from the stimulus length

`timescale 1ns/1ps
`default_nettype none

module tb_host_chan_events
    import host_chan_events_pkg::*;
();

    localparam int NUM_CH          = 2;
    localparam int BUF_DEPTH       = 4;
    localparam int CYCLES_PER_LINE = 20;
    localparam int SPARE_CYCLES    = 1000;
    localparam int IDLE_CYCLES     = 16;
    localparam string STIM_FILE    = "verif/host_chan_events_stim.txt";

    logic                      clk;
    logic                      reset;
    logic                      en_tx;
    logic [NUM_CH-1:0]         tx_valid;
    logic [NUM_CH-1:0]         tx_sop;
    logic [NUM_CH-1:0]         tx_irq;
    t_fmttype [NUM_CH-1:0]     tx_fmttype;
    t_tlp_length [NUM_CH-1:0]  tx_length;
    logic                      en_rx;
    logic [NUM_CH-1:0]         rx_valid;
    logic [NUM_CH-1:0]         rx_sop;
    t_fmttype [NUM_CH-1:0]     rx_fmttype;
    t_tlp_length [NUM_CH-1:0]  rx_length;
    logic                      hold;

    t_event_total              total_req_dwords;
    t_event_total              total_rsp_dwords;
    logic signed [48:0]        outstanding_dwords;

    logic                      check_now;
    logic [8*24-1:0]           test_name;
    t_event_total              file_req;
    t_event_total              file_rsp;
    int                        pass_count;
    int                        fail_count;

    logic [8*160-1:0]          text;
    int                        line_count;
    int                        stim_errors;
    logic                      limit_ready;

    initial
        clk = 1'b0;
    always #2 clk = ~clk;

    host_chan_events_top #(
        .NUM_CH    (NUM_CH),
        .BUF_DEPTH (BUF_DEPTH)
    ) DUT (
        .clk (clk), .reset (reset),
        .en_tx (en_tx), .tx_valid (tx_valid), .tx_sop (tx_sop), .tx_irq (tx_irq),
        .tx_fmttype (tx_fmttype), .tx_length (tx_length),
        .en_rx (en_rx), .rx_valid (rx_valid), .rx_sop (rx_sop),
        .rx_fmttype (rx_fmttype), .rx_length (rx_length),
        .hold (hold),
        .total_req_dwords (total_req_dwords), .total_rsp_dwords (total_rsp_dwords),
        .outstanding_dwords (outstanding_dwords)
    );

    event_checker #(
        .NUM_CH (NUM_CH)
    ) compare (
        .clk (clk), .reset (reset),
        .en_tx (en_tx), .tx_valid (tx_valid), .tx_sop (tx_sop), .tx_irq (tx_irq),
        .tx_fmttype (tx_fmttype), .tx_length (tx_length),
        .en_rx (en_rx), .rx_valid (rx_valid), .rx_sop (rx_sop),
        .rx_fmttype (rx_fmttype), .rx_length (rx_length),
        .total_req_dwords (total_req_dwords), .total_rsp_dwords (total_rsp_dwords),
        .outstanding_dwords (outstanding_dwords),
        .check_now (check_now), .test_name (test_name),
        .file_req (file_req), .file_rsp (file_rsp),
        .pass_count (pass_count), .fail_count (fail_count)
    );

    // All traffic off and hold released
    task automatic idle_inputs();
        en_tx      = 1'b0;
        tx_valid   = '0;
        tx_sop     = '0;
        tx_irq     = '0;
        tx_fmttype = '0;
        tx_length  = '0;
        en_rx      = 1'b0;
        rx_valid   = '0;
        rx_sop     = '0;
        rx_fmttype = '0;
        rx_length  = '0;
        hold       = 1'b0;
    endtask

    // Line count sets the watchdog limit before the replay starts
    task automatic count_stim_lines();
        int fd;

        line_count = 0;
        fd = $fopen(STIM_FILE, "r");
        if (fd != 0)
        begin
            while ($fgets(text, fd) != 0)
                line_count = line_count + 1;
            $fclose(fd);
        end
    endtask

    // One beat line drives every channel field for one clock cycle
    task automatic apply_beat();
        logic [8*8-1:0] kind;
        logic           e_tx;
        logic           e_rx;
        logic           h;
        logic [NUM_CH-1:0] tv, ts, ti, rv, rs;
        t_fmttype       tf0, tf1, rf0, rf1;
        t_tlp_length    tl0, tl1, rl0, rl1;
        int             n;

        n = $sscanf(text, "%s %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h",
                    kind, e_tx, e_rx, h, tv, ts, ti, tf0, tl0, tf1, tl1,
                    rv, rs, rf0, rl0, rf1, rl1);
        if (n != 17)
        begin
            $display("Beat line in the stim file has %0d fields instead of 17", n);
            stim_errors = stim_errors + 1;
        end
        else
        begin
            @(posedge clk);
            #0.5;
            en_tx      = e_tx;
            en_rx      = e_rx;
            hold       = h;
            tx_valid   = tv;
            tx_sop     = ts;
            tx_irq     = ti;
            tx_fmttype = {tf1, tf0};
            tx_length  = {tl1, tl0};
            rx_valid   = rv;
            rx_sop     = rs;
            rx_fmttype = {rf1, rf0};
            rx_length  = {rl1, rl0};
        end
    endtask

    // Test end drains the monitor before the checker looks at the totals
    task automatic finish_test();
        logic [8*8-1:0]  kind;
        logic [8*24-1:0] name;
        t_event_total    er;
        t_event_total    es;
        int              n;

        n = $sscanf(text, "%s %s %h %h", kind, name, er, es);
        if (n != 4)
        begin
            $display("End marker in the stim file is missing its name or expected totals");
            stim_errors = stim_errors + 1;
        end
        else
        begin
            @(posedge clk);
            #0.5;
            idle_inputs();
            repeat (IDLE_CYCLES) @(posedge clk);
            #0.5;
            test_name = name;
            file_req  = er;
            file_rsp  = es;
            check_now = 1'b1;
            @(posedge clk);
            #0.5;
            check_now = 1'b0;
        end
    endtask

    initial
    begin
        wait (limit_ready);
        repeat (line_count * CYCLES_PER_LINE + SPARE_CYCLES) @(posedge clk);
        $display("Timeout: the stimulus did not finish within %0d cycles",
                 line_count * CYCLES_PER_LINE + SPARE_CYCLES);
        $display("test failed");
        $finish;
    end

    initial
    begin
        int             fd;
        logic [8*8-1:0] kind;

        reset       = 1'b1;
        check_now   = 1'b0;
        test_name   = '0;
        file_req    = '0;
        file_rsp    = '0;
        stim_errors = 0;
        limit_ready = 1'b0;
        idle_inputs();
        count_stim_lines();
        limit_ready = 1'b1;

        repeat (8) @(posedge clk);
        #0.5;
        reset = 1'b0;

        fd = $fopen(STIM_FILE, "r");
        if (fd == 0)
        begin
            $display("Could not open the stim file %0s", STIM_FILE);
            stim_errors = stim_errors + 1;
        end
        else
        begin
            while ($fgets(text, fd) != 0)
            begin
                if ($sscanf(text, "%s", kind) == 1)
                begin
                    if (kind == "B")
                        apply_beat();
                    else if (kind == "E")
                        finish_test();
                    else if (kind != "#")
                    begin
                        $display("Stim file line starts with an unknown kind %0s", kind);
                        stim_errors = stim_errors + 1;
                    end
                end
            end
            $fclose(fd);
        end

        repeat (2) @(posedge clk);
        $display("Summary: %0d tests ok, %0d tests failing, %0d stimulus errors",
                 pass_count, fail_count, stim_errors);
        if ((fail_count == 0) && (stim_errors == 0) && (pass_count > 0))
            $display("test passed");
        else
            $display("test failed");
        $finish;
    end

endmodule

`default_nettype wire

/* verif/host_chan_events_stim.txt */
# B en_tx en_rx hold tx_valid tx_sop tx_irq tx_fmt0 tx_len0 tx_fmt1 tx_len1 rx_valid rx_sop rx_fmt0 rx_len0 rx_fmt1 rx_len1
# E name expected_total_req expected_total_rsp   (all values hex, bit 0 of a mask is channel 0)
E reset_zero 0 0
B 1 1 0 3 3 0 00 010 20 000 0 0 00 000 00 000
B 1 1 0 1 1 0 20 004 00 000 0 0 00 000 00 000
E two_ch_reads 414 0
B 1 1 0 3 3 2 00 002 00 008 0 0 00 000 00 000
B 1 1 0 3 2 0 00 008 40 008 0 0 00 000 00 000
B 0 1 0 3 3 0 00 008 20 008 0 0 00 000 00 000
B 1 1 0 0 0 0 00 000 00 000 3 3 0A 008 40 008
B 1 0 0 0 0 0 00 000 00 000 3 3 4A 008 4A 008
B 1 1 0 0 0 0 00 000 00 000 3 0 4A 008 4A 008
E filtered 416 0
B 1 1 0 0 0 0 00 000 00 000 3 3 4A 010 4A 004
B 1 1 0 1 1 0 00 020 00 000 1 1 4A 000 00 000
E completions 436 414
B 1 1 1 3 3 0 00 010 20 020 1 1 4A 008 00 000
B 1 1 1 3 3 0 00 010 20 020 1 1 4A 008 00 000
B 1 1 1 3 3 0 00 010 20 020 1 1 4A 008 00 000
B 1 1 1 3 3 0 00 010 20 020 1 1 4A 008 00 000
B 1 1 1 3 3 0 00 010 20 020 1 1 4A 008 00 000
B 1 1 1 3 3 0 00 010 20 020 1 1 4A 008 00 000
B 1 1 1 3 3 0 00 010 20 020 1 1 4A 008 00 000
B 1 1 1 3 3 0 00 010 20 020 1 1 4A 008 00 000
B 1 1 1 3 3 0 00 010 20 020 1 1 4A 008 00 000
B 1 1 1 3 3 0 00 010 20 020 1 1 4A 008 00 000
E hold_coalesce 616 464
B 1 1 0 2 2 0 00 000 20 100 2 2 00 000 4A 002
E after_hold 716 466

/* project.f */
rtl/host_chan_events_pkg.sv
rtl/tlp_read_tracker.sv
rtl/event_credit_fifo.sv
rtl/event_accumulator.sv
rtl/host_chan_events_top.sv
verif/event_checker.sv
verif/tb_host_chan_events.sv

/* Bender.yml */
package:
  name: host_chan_events

sources:
  - rtl/host_chan_events_pkg.sv
  - rtl/tlp_read_tracker.sv
  - rtl/event_credit_fifo.sv
  - rtl/event_accumulator.sv
  - rtl/host_chan_events_top.sv
  - target: test
    files:
      - verif/event_checker.sv
      - verif/tb_host_chan_events.sv
